//--- rtl/corePkg.sv
`default_nettype none

package corePkg;

    localparam int DATA_WIDTH = 32;
    localparam int NUM_ARCH_REGS = 16;   // r0 reads as zero
    localparam int ROB_SIZE = 8;
    localparam int IQ_SIZE = 4;
    localparam int DIV_STEPS = 32;

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] RegIdx;
    typedef logic [$clog2(ROB_SIZE)-1:0] Tag;
    typedef logic [$clog2(ROB_SIZE):0] RobCount;
    typedef logic [$clog2(IQ_SIZE)-1:0] IqIdx;
    typedef logic [$clog2(DIV_STEPS)-1:0] DivCount;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr, opXor, opSlt, opSll, opSrl, opDiv, opRem
    } Opcode;

    typedef struct packed {
        Opcode op;
        RegIdx rd;
        RegIdx rs1;
        RegIdx rs2;
        logic useImm;   // imm takes the place of rs2
        logic [DATA_WIDTH-1:0] imm;
    } DispatchUOp;

    typedef struct packed {
        logic ready;
        Tag tag;
        logic [DATA_WIDTH-1:0] value;
    } Operand;

    typedef struct packed {
        Opcode op;
        Tag tagDst;
        Operand src1;
        Operand src2;
    } IssueUOp;

    typedef struct packed {
        logic valid;
        Tag tag;
        logic [DATA_WIDTH-1:0] value;
    } ResultBus;

    typedef struct packed {
        RegIdx rd;
        Tag tag;
        logic [DATA_WIDTH-1:0] value;
    } CommitInfo;

endpackage

`default_nettype wire

//--- rtl/renameUnit.sv
`timescale 1ns/10ps
`default_nettype none

module renameUnit
(
    input wire clk,
    input wire rst,
    input wire dispatchValid,
    input wire corePkg::DispatchUOp dispatchUOp,
    output logic dispatchReady,
    input wire iqFull,
    input wire robFull,
    input wire corePkg::Tag allocTag,
    output logic robAlloc,
    output corePkg::RegIdx allocRd,
    output corePkg::Tag [1:0] robReadTag,
    input wire [1:0] robReadDone,
    input wire [1:0][corePkg::DATA_WIDTH-1:0] robReadValue,
    input wire corePkg::ResultBus wbBus,
    input wire commitValid,
    input wire corePkg::CommitInfo commit,
    output corePkg::IssueUOp renamed,
    output logic insert
);
    logic [corePkg::DATA_WIDTH-1:0] archRegs [corePkg::NUM_ARCH_REGS];
    corePkg::Tag aliasTag [corePkg::NUM_ARCH_REGS];
    logic [corePkg::NUM_ARCH_REGS-1:0] pending;   // register has an in-flight producer
    corePkg::RegIdx srcReg [2];
    corePkg::Operand srcOp [2];
    logic accept;

    assign dispatchReady = !iqFull && !robFull;
    assign accept = dispatchValid && dispatchReady;
    assign robAlloc = accept;
    assign allocRd = dispatchUOp.rd;
    assign srcReg[0] = dispatchUOp.rs1;
    assign srcReg[1] = dispatchUOp.rs2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            robReadTag[i] = aliasTag[srcReg[i]];
            srcOp[i].ready = 1'b1;
            srcOp[i].tag = aliasTag[srcReg[i]];
            if (!pending[srcReg[i]])
                srcOp[i].value = (srcReg[i] == '0) ? '0 : archRegs[srcReg[i]];
            else if (wbBus.valid && wbBus.tag == aliasTag[srcReg[i]])
                srcOp[i].value = wbBus.value;   // producer writing back right now
            else if (robReadDone[i])
                srcOp[i].value = robReadValue[i];
            else begin
                srcOp[i].ready = 1'b0;
                srcOp[i].value = '0;
            end
        end
        if (dispatchUOp.useImm) begin
            srcOp[1].ready = 1'b1;
            srcOp[1].tag = '0;
            srcOp[1].value = dispatchUOp.imm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            insert <= 1'b0;
        end else begin
            // only the youngest producer may clear the entry
            if (commitValid && pending[commit.rd] && aliasTag[commit.rd] == commit.tag)
                pending[commit.rd] <= 1'b0;
            if (accept && dispatchUOp.rd != '0)
                pending[dispatchUOp.rd] <= 1'b1;
            insert <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aliasTag[dispatchUOp.rd] <= allocTag;
            renamed <= '{op: dispatchUOp.op, tagDst: allocTag, src1: srcOp[0], src2: srcOp[1]};
        end
        if (commitValid && commit.rd != '0)
            archRegs[commit.rd] <= commit.value;
    end

endmodule

`default_nettype wire

//--- rtl/issueQueue.sv
`timescale 1ns/10ps
`default_nettype none

module issueQueue
(
    input wire clk,
    input wire rst,
    input wire insert,
    input wire corePkg::IssueUOp renamed,
    output logic full,
    input wire corePkg::ResultBus wbBus,
    input wire divBusy,
    output corePkg::IssueUOp aluIssue,
    output logic aluIssueValid,
    output corePkg::IssueUOp divIssue,
    output logic divIssueValid
);
    corePkg::IssueUOp slot [corePkg::IQ_SIZE];
    logic [corePkg::IQ_SIZE-1:0] valid;
    logic [corePkg::IQ_SIZE-1:0] older [corePkg::IQ_SIZE];   // older[i][j]: i came before j
    logic [corePkg::IQ_SIZE-1:0] aluReady, divReady, aluPick, divPick;
    corePkg::IqIdx insIdx;
    int used;

    function automatic corePkg::Operand wake(corePkg::Operand op, corePkg::ResultBus wb);
        corePkg::Operand res;
        res = op;
        if (!op.ready && wb.valid && wb.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = wb.value;
        end
        return res;
    endfunction

    // the uop sitting in rename also needs a slot
    assign full = (used + int'(insert)) >= corePkg::IQ_SIZE;

    always_comb begin
        used = 0;
        insIdx = '0;
        for (int i = corePkg::IQ_SIZE - 1; i >= 0; i--) begin
            if (valid[i])
                used = used + 1;
            else
                insIdx = corePkg::IqIdx'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < corePkg::IQ_SIZE; i++) begin
            aluReady[i] = valid[i] && slot[i].src1.ready && slot[i].src2.ready
                && slot[i].op != corePkg::opDiv && slot[i].op != corePkg::opRem;
            divReady[i] = valid[i] && slot[i].src1.ready && slot[i].src2.ready
                && (slot[i].op == corePkg::opDiv || slot[i].op == corePkg::opRem) && !divBusy;
        end
        aluPick = aluReady;
        divPick = divReady;
        for (int i = 0; i < corePkg::IQ_SIZE; i++) begin
            for (int j = 0; j < corePkg::IQ_SIZE; j++) begin
                if (aluReady[j] && older[j][i]) aluPick[i] = 1'b0;
                if (divReady[j] && older[j][i]) divPick[i] = 1'b0;
            end
        end
        aluIssue = '0;
        divIssue = '0;
        for (int i = 0; i < corePkg::IQ_SIZE; i++) begin
            if (aluPick[i]) aluIssue = slot[i];
            if (divPick[i]) divIssue = slot[i];
        end
        aluIssueValid = |aluPick;
        divIssueValid = |divPick;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            valid <= valid & ~aluPick & ~divPick;
            if (insert) valid[insIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < corePkg::IQ_SIZE; i++) begin
            slot[i].src1 <= wake(slot[i].src1, wbBus);
            slot[i].src2 <= wake(slot[i].src2, wbBus);
        end
        if (insert) begin
            slot[insIdx] <= '{op: renamed.op, tagDst: renamed.tagDst,
                src1: wake(renamed.src1, wbBus), src2: wake(renamed.src2, wbBus)};
            for (int j = 0; j < corePkg::IQ_SIZE; j++) begin
                older[insIdx][j] <= 1'b0;
                older[j][insIdx] <= valid[j];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/intAlu.sv
`timescale 1ns/10ps
`default_nettype none

module intAlu
(
    input wire clk,
    input wire rst,
    input wire corePkg::IssueUOp aluIssue,
    input wire aluIssueValid,
    output corePkg::ResultBus result
);
    logic [corePkg::DATA_WIDTH-1:0] a, b, res, resValue;
    corePkg::Tag resTag;
    logic resValid;

    assign a = aluIssue.src1.value;
    assign b = aluIssue.src2.value;
    assign result = '{valid: resValid, tag: resTag, value: resValue};

    always_comb begin
        case (aluIssue.op)
            corePkg::opAdd: res = a + b;
            corePkg::opSub: res = a - b;
            corePkg::opAnd: res = a & b;
            corePkg::opOr: res = a | b;
            corePkg::opXor: res = a ^ b;
            corePkg::opSlt: res = {{(corePkg::DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
            corePkg::opSll: res = a << b[4:0];   // shamt is low 5 bits
            corePkg::opSrl: res = a >> b[4:0];
            default: res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) resValid <= 1'b0;
        else resValid <= aluIssueValid;
    end

    always_ff @(posedge clk) begin
        resTag <= aluIssue.tagDst;
        resValue <= res;
    end

endmodule

`default_nettype wire

//--- rtl/divider.sv
`timescale 1ns/10ps
`default_nettype none

module divider
(
    input wire clk,
    input wire rst,
    input wire corePkg::IssueUOp divIssue,
    input wire divIssueValid,
    input wire aluWbValid,
    output logic divBusy,
    output corePkg::ResultBus result
);
    typedef enum logic [1:0] {idle, running, waitWb} DivState;

    DivState state;
    corePkg::DivCount count;
    corePkg::Tag dstTag;
    logic wantRem;
    logic [corePkg::DATA_WIDTH-1:0] quot, rem, divisor;
    logic [corePkg::DATA_WIDTH:0] partial, diff;

    // restoring step, top bit of diff set means partial < divisor
    assign partial = {rem, quot[corePkg::DATA_WIDTH-1]};
    assign diff = partial - {1'b0, divisor};

    assign divBusy = state != idle;
    assign result = '{valid: state == waitWb && !aluWbValid, tag: dstTag,
                      value: wantRem ? rem : quot};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: if (divIssueValid) state <= running;
                running: if (count == '0) state <= waitWb;
                waitWb: if (!aluWbValid) state <= idle;   // alu has priority on wb
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && divIssueValid) begin
            quot <= divIssue.src1.value;
            divisor <= divIssue.src2.value;
            rem <= '0;
            dstTag <= divIssue.tagDst;
            wantRem <= divIssue.op == corePkg::opRem;
            count <= corePkg::DivCount'(corePkg::DIV_STEPS - 1);
        end else if (state == running) begin
            count <= count - corePkg::DivCount'(1);
            // zero divisor always subtracts, leaving all ones and the dividend
            if (!diff[corePkg::DATA_WIDTH]) begin
                rem <= diff[corePkg::DATA_WIDTH-1:0];
                quot <= {quot[corePkg::DATA_WIDTH-2:0], 1'b1};
            end else begin
                rem <= partial[corePkg::DATA_WIDTH-1:0];
                quot <= {quot[corePkg::DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/reorderBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorderBuffer
(
    input wire clk,
    input wire rst,
    input wire robAlloc,
    input wire corePkg::RegIdx allocRd,
    output corePkg::Tag allocTag,
    output logic full,
    input wire corePkg::Tag [1:0] robReadTag,
    output logic [1:0] robReadDone,
    output logic [1:0][corePkg::DATA_WIDTH-1:0] robReadValue,
    input wire corePkg::ResultBus wbBus,
    input wire commitReady,
    output logic commitValid,
    output corePkg::CommitInfo commit
);
    corePkg::RegIdx entryRd [corePkg::ROB_SIZE];
    logic [corePkg::DATA_WIDTH-1:0] entryValue [corePkg::ROB_SIZE];
    logic [corePkg::ROB_SIZE-1:0] entryDone;
    corePkg::Tag head, tail;
    corePkg::RobCount count;
    logic commitFire;

    assign allocTag = tail;
    assign full = count == corePkg::RobCount'(corePkg::ROB_SIZE);
    assign commitValid = count != '0 && entryDone[head];
    assign commitFire = commitValid && commitReady;
    assign commit = '{rd: entryRd[head], tag: head, value: entryValue[head]};

    // operand lookup for rename
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            robReadDone[i] = entryDone[robReadTag[i]];
            robReadValue[i] = entryValue[robReadTag[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            entryDone <= '0;
        end else begin
            if (wbBus.valid) entryDone[wbBus.tag] <= 1'b1;
            if (robAlloc) begin
                entryDone[tail] <= 1'b0;
                tail <= tail + corePkg::Tag'(1);
            end
            if (commitFire) head <= head + corePkg::Tag'(1);
            if (robAlloc && !commitFire)
                count <= count + corePkg::RobCount'(1);
            else if (!robAlloc && commitFire)
                count <= count - corePkg::RobCount'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (robAlloc) entryRd[tail] <= allocRd;
        if (wbBus.valid) entryValue[wbBus.tag] <= wbBus.value;
    end

endmodule

`default_nettype wire

//--- rtl/coreTop.sv
`timescale 1ns/10ps
`default_nettype none

module coreTop
(
    input wire clk,
    input wire rst,
    input wire dispatchValid,
    input wire corePkg::DispatchUOp dispatchUOp,
    output logic dispatchReady,
    output logic commitValid,
    output corePkg::CommitInfo commit,
    input wire commitReady
);
    logic iqFull, robFull, robAlloc, insert, commitFire;
    logic aluIssueValid, divIssueValid, divBusy;
    logic [1:0] robReadDone;
    logic [1:0][corePkg::DATA_WIDTH-1:0] robReadValue;
    corePkg::Tag [1:0] robReadTag;
    corePkg::Tag allocTag;
    corePkg::RegIdx allocRd;
    corePkg::IssueUOp renamed, aluIssue, divIssue;
    corePkg::ResultBus aluResult, divResult, wbBus;

    assign commitFire = commitValid && commitReady;
    assign wbBus = aluResult.valid ? aluResult : divResult;   // div only drives when alu idle

    renameUnit rn
    (
        .clk(clk), .rst(rst),
        .dispatchValid(dispatchValid), .dispatchUOp(dispatchUOp),
        .dispatchReady(dispatchReady),
        .iqFull(iqFull), .robFull(robFull),
        .allocTag(allocTag), .robAlloc(robAlloc), .allocRd(allocRd),
        .robReadTag(robReadTag), .robReadDone(robReadDone), .robReadValue(robReadValue),
        .wbBus(wbBus),
        .commitValid(commitFire), .commit(commit),
        .renamed(renamed), .insert(insert)
    );

    issueQueue iq
    (
        .clk(clk), .rst(rst),
        .insert(insert), .renamed(renamed), .full(iqFull),
        .wbBus(wbBus), .divBusy(divBusy),
        .aluIssue(aluIssue), .aluIssueValid(aluIssueValid),
        .divIssue(divIssue), .divIssueValid(divIssueValid)
    );

    intAlu ialu
    (
        .clk(clk), .rst(rst),
        .aluIssue(aluIssue), .aluIssueValid(aluIssueValid),
        .result(aluResult)
    );

    divider div
    (
        .clk(clk), .rst(rst),
        .divIssue(divIssue), .divIssueValid(divIssueValid),
        .aluWbValid(aluResult.valid), .divBusy(divBusy),
        .result(divResult)
    );

    reorderBuffer rob
    (
        .clk(clk), .rst(rst),
        .robAlloc(robAlloc), .allocRd(allocRd), .allocTag(allocTag), .full(robFull),
        .robReadTag(robReadTag), .robReadDone(robReadDone), .robReadValue(robReadValue),
        .wbBus(wbBus),
        .commitReady(commitReady), .commitValid(commitValid), .commit(commit)
    );

endmodule

`default_nettype wire

//--- dv/coreTb.sv
`timescale 1ns/10ps
`default_nettype none

module coreTb;
    localparam int MAX_OPS = 64;
    localparam int DISPATCH_LIMIT = 500;
    localparam int COMMIT_LIMIT = 3000;
    localparam int STALL_CYCLES = 25;

    logic clk, rst, dispatchValid, dispatchReady, commitValid, commitReady;
    corePkg::DispatchUOp dispatchUOp;
    corePkg::CommitInfo commit;

    logic [51:0] prog [MAX_OPS];
    corePkg::RegIdx expRd [MAX_OPS];
    logic [31:0] expValue [MAX_OPS];
    logic [31:0] refRegs [corePkg::NUM_ARCH_REGS];
    logic [31:0] dispatchSeed, commitSeed;
    int numOps, commitCount, cycle;
    logic sawStall;

    coreTop dut
    (
        .clk(clk), .rst(rst),
        .dispatchValid(dispatchValid), .dispatchUOp(dispatchUOp),
        .dispatchReady(dispatchReady),
        .commitValid(commitValid), .commit(commit), .commitReady(commitReady)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // op, rd, rs1, rs2 and useImm take one hex digit each, then 8 digits of imm
    function automatic corePkg::DispatchUOp toUOp(input logic [51:0] line);
        corePkg::DispatchUOp uop;
        uop.op = corePkg::Opcode'(line[51:48]);
        uop.rd = line[47:44];
        uop.rs1 = line[43:40];
        uop.rs2 = line[39:36];
        uop.useImm = line[32];
        uop.imm = line[31:0];
        return uop;
    endfunction

    function automatic logic [31:0] refResult(input corePkg::Opcode op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            corePkg::opAdd: return a + b;
            corePkg::opSub: return a - b;
            corePkg::opAnd: return a & b;
            corePkg::opOr: return a | b;
            corePkg::opXor: return a ^ b;
            corePkg::opSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            corePkg::opSll: return a << b[4:0];
            corePkg::opSrl: return a >> b[4:0];
            corePkg::opDiv: return (b == 32'd0) ? 32'hffffffff : a / b;
            corePkg::opRem: return (b == 32'd0) ? a : a % b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortOnTimeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // long hold at the start fills the ROB before the random low cycles
    always @(posedge clk) begin
        #1;
        cycle++;
        if (cycle < STALL_CYCLES) begin
            commitReady = 1'b0;
        end else begin
            commitSeed = lcgNext(commitSeed);
            commitReady = commitSeed[27:26] != 2'b00;
        end
    end

    always @(negedge clk) begin
        if (commitValid && commitReady) begin
            if (commitCount >= numOps) begin
                $display("an extra commit appeared after the last micro-op at %0t", $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "unexpected commit");
            end else begin
                checkValue("commit.rd", 32'(commit.rd), 32'(expRd[commitCount]));
                checkValue("commit.value", commit.value, expValue[commitCount]);
                checkValue("commit.tag", 32'(commit.tag), 32'(commitCount % corePkg::ROB_SIZE));
                commitCount++;
            end
        end
    end

    initial begin
        int waitCycles;
        logic [31:0] a, b;
        corePkg::DispatchUOp uop;
        clk = 1'b0;
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatchUOp = '0;
        commitReady = 1'b0;
        dispatchSeed = 32'h318f;
        commitSeed = 32'h318f;
        commitCount = 0;
        cycle = 0;
        sawStall = 1'b0;
        for (int i = 0; i < MAX_OPS; i++)
            prog[i] = {4'hf, 48'(i)};   // opcode f marks an unused line
        $readmemh("dv/coreTestdata.txt", prog);
        numOps = 0;
        while (numOps < MAX_OPS && prog[numOps][51:48] != 4'hf)
            numOps++;

        // reference model runs in program order and never writes r0
        for (int i = 0; i < corePkg::NUM_ARCH_REGS; i++)
            refRegs[i] = 32'd0;
        for (int i = 0; i < numOps; i++) begin
            uop = toUOp(prog[i]);
            a = refRegs[uop.rs1];
            b = uop.useImm ? uop.imm : refRegs[uop.rs2];
            expRd[i] = uop.rd;
            expValue[i] = refResult(uop.op, a, b);
            if (uop.rd != '0)
                refRegs[uop.rd] = expValue[i];
        end

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        checkValue("commitValid", 32'(commitValid), 32'd0);
        checkValue("dispatchReady", 32'(dispatchReady), 32'd1);
        @(posedge clk);
        #1;

        for (int i = 0; i < numOps; i++) begin
            dispatchSeed = lcgNext(dispatchSeed);
            if (dispatchSeed[31:30] == 2'b00) begin   // idle cycle
                @(posedge clk);
                #1;
            end
            dispatchValid = 1'b1;
            dispatchUOp = toUOp(prog[i]);
            waitCycles = 0;
            @(negedge clk);
            while (!dispatchReady) begin
                sawStall = 1'b1;
                waitCycles++;
                if (waitCycles > DISPATCH_LIMIT)
                    abortOnTimeout("dispatchReady");
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            dispatchValid = 1'b0;
        end

        waitCycles = 0;
        while (commitCount < numOps) begin
            waitCycles++;
            if (waitCycles > COMMIT_LIMIT)
                abortOnTimeout("all commits");
            @(posedge clk);
        end
        repeat (20) @(posedge clk);   // room for a duplicate to show up
        checkValue("dispatchReady low seen", 32'(sawStall), 32'd1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/coreTestdata.txt
// one micro-op per line: op rd rs1 rs2 useImm (one hex digit each), imm (8 hex digits)
// op: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 srl 8 div 9 rem
0100100000007 // r1 = 7
02001FFFFFFF9 // r2 = -7
0300100000064 // r3 = 100
1412000000000 // r4 = r1 - r2
2543000000000 // r5 = r4 & r3
36501F0F00000 // r6 = r5 | imm
4762000000000 // r7 = r6 ^ r2
5821000000000 // r8 = r2 < r1 signed
5912000000000 // r9 = r1 < r2 signed
6A10100000023 // r10 = r1 << 35
7B20100000024 // r11 = r2 >> 36
8C31000000000 // r12 = r3 / r1
9D31000000000 // r13 = r3 % r1
0ECD000000000 // r14 = r12 + r13
8F20000000000 // r15 = r2 / r0
8923000000000 // r9 = r2 / r3 unsigned
9130000000000 // r1 = r3 % r0
0030100000005 // r0 = r3 + 5
020F000000000 // r2 = r0 + r15
6311000000000 // r3 = r1 << r1
1430000000000 // r4 = r3 - r0
7548000000000 // r5 = r4 >> r8

//--- tb.f
rtl/corePkg.sv
rtl/renameUnit.sv
rtl/issueQueue.sv
rtl/intAlu.sv
rtl/divider.sv
rtl/reorderBuffer.sv
rtl/coreTop.sv
dv/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module coreTb -o coreTb

out="$(./obj_dir/coreTb)" || { echo "$out"; exit 1; }
echo "$out"
if ! echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 1
fi
